//--- hw/obi_sys_pkg.sv
// OBI request/response structs, peripheral write struct and address map constants

package obi_sys_pkg;

    // ----------------------------------------
    // OBI channels
    // ----------------------------------------

    // Request channel as driven by a core-side master
    typedef struct packed {
        // Address phase request
        logic        req;
        // Odd parity companion of req, expected to be ~req
        logic        reqpar;
        // Write enable
        logic        we;
        // Byte enables, one per lane
        logic [3:0]  be;
        // Byte address
        logic [31:0] addr;
        // Write data
        logic [31:0] wdata;
    } obi_req_t;

    // Response channel returned by the memory side
    typedef struct packed {
        // Grant, same cycle as req
        logic        gnt;
        // Response valid, one cycle after the grant
        logic        rvalid;
        // Error flag, qualified by rvalid
        logic        err;
        // Read data, qualified by rvalid
        logic [31:0] rdata;
    } obi_rsp_t;

    // ----------------------------------------
    // Virtual peripheral write
    // ----------------------------------------

    // One write cycle into the peripheral block
    typedef struct packed {
        // Write strobe
        logic        stb;
        // Register select, 0 is stdout and 1 is status
        logic        sel;
        // Byte enables, carried along but not used by the registers
        logic [3:0]  be;
        // Write data
        logic [31:0] wdata;
    } vp_wr_t;

    // ----------------------------------------
    // Address map
    // ----------------------------------------

    // Upper address half that marks the peripheral region
    localparam logic [15:0] VP_BASE = 16'h8000;

    // Register offsets inside the peripheral region, word aligned
    localparam logic [15:0] VP_STDOUT_OFS = 16'h0000;
    localparam logic [15:0] VP_STATUS_OFS = 16'h0004;

endpackage : obi_sys_pkg

//--- hw/dp_ram.sv
// Dual-port word RAM, read-only port a and byte-writable port b

`timescale 1ns/100ps

module dp_ram #(
    parameter int unsigned RAM_ADDR_WIDTH = 12
) (
    input  logic                      clk_i,

    // Port a, read only
    input  logic                      a_en_i,
    input  logic [RAM_ADDR_WIDTH-3:0] a_addr_i,
    output logic [31:0]               a_rdata_o,

    // Port b, read or byte-lane write
    input  logic                      b_en_i,
    input  logic                      b_we_i,
    input  logic [3:0]                b_be_i,
    input  logic [RAM_ADDR_WIDTH-3:0] b_addr_i,
    input  logic [31:0]               b_wdata_i,
    output logic [31:0]               b_rdata_o
);

    // Number of 32-bit words in the array
    localparam int unsigned DEPTH = 2 ** (RAM_ADDR_WIDTH - 2);

    logic [31:0] mem_q [DEPTH];

    // ----------------------------------------
    // Port a
    // ----------------------------------------

    // Registered read, old contents on a same-word write from port b
    always_ff @(posedge clk_i) begin
        if (a_en_i) begin
            a_rdata_o <= mem_q[a_addr_i];
        end
    end

    // ----------------------------------------
    // Port b
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (b_en_i) begin
            // Read sees the word before this cycle's write
            b_rdata_o <= mem_q[b_addr_i];
            if (b_we_i) begin
                // Only enabled lanes change
                for (int i = 0; i < 4; i++) begin
                    if (b_be_i[i]) begin
                        mem_q[b_addr_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule : dp_ram

//--- hw/vp_periph.sv
// Stdout character and test-exit status virtual peripherals

`timescale 1ns/100ps

module vp_periph import obi_sys_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,

    // Write from the data port
    input  vp_wr_t      vp_wr_i,
    // Status readback
    output logic [31:0] vp_rdata_o,

    // Character output
    output logic [7:0]  stdout_char_o,
    output logic        stdout_valid_o,

    // Test exit
    output logic        exit_valid_o,
    output logic [31:0] exit_code_o
);

    logic stdout_wr;
    logic status_wr;

    // Register selects, byte enables play no part here
    assign stdout_wr = vp_wr_i.stb & ~vp_wr_i.sel;
    assign status_wr = vp_wr_i.stb &  vp_wr_i.sel;

    // ----------------------------------------
    // Stdout
    // ----------------------------------------

    // Character byte, only the low lane is kept
    always_ff @(posedge clk_i) begin
        if (stdout_wr) begin
            stdout_char_o <= vp_wr_i.wdata[7:0];
        end
    end

    // One-cycle valid per write
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stdout_valid_o <= 1'b0;
        end else begin
            stdout_valid_o <= stdout_wr;
        end
    end

    // ----------------------------------------
    // Exit status
    // ----------------------------------------

    // Sticky until reset, a second status write only updates the code
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exit_valid_o <= 1'b0;
        end else if (status_wr) begin
            exit_valid_o <= 1'b1;
        end
    end

    // Status word
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exit_code_o <= '0;
        end else if (status_wr) begin
            exit_code_o <= vp_wr_i.wdata;
        end
    end

    // The port picks this only for status reads
    assign vp_rdata_o = exit_code_o;

endmodule : vp_periph

//--- hw/obi_resp_port.sv
// OBI slave port with request parity check, address decode, grant and registered response

`timescale 1ns/100ps

module obi_resp_port import obi_sys_pkg::*; #(
    parameter int unsigned RAM_ADDR_WIDTH = 12,
    parameter bit          HAS_VP         = 1'b0
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // OBI slave side
    input  obi_req_t                  req_i,
    output obi_rsp_t                  rsp_o,

    // RAM access, word addressed
    output logic                      ram_en_o,
    output logic                      ram_we_o,
    output logic [3:0]                ram_be_o,
    output logic [RAM_ADDR_WIDTH-3:0] ram_addr_o,
    output logic [31:0]               ram_wdata_o,
    input  logic [31:0]               ram_rdata_i,

    // Virtual peripheral access
    output vp_wr_t                    vp_wr_o,
    input  logic [31:0]               vp_rdata_i,

    // Request parity mismatch, same cycle as the request
    output logic                      par_err_o
);

    // ----------------------------------------
    // Request checks and decode
    // ----------------------------------------

    logic par_err;
    logic req_ok;
    logic ram_hit;
    logic vp_stdout_hit;
    logic vp_status_hit;
    logic vp_hit;

    // reqpar has to be the inverse of req, equal values are a fault
    assign par_err = req_i.req & (req_i.reqpar == req_i.req);

    // A request that may touch RAM or peripherals
    assign req_ok = req_i.req & ~par_err;

    // RAM sits at the bottom, all bits above the RAM window must be zero
    assign ram_hit = (req_i.addr[31:RAM_ADDR_WIDTH] == '0);

    // Peripheral region only on ports that have the peripheral path
    assign vp_stdout_hit = HAS_VP && (req_i.addr[31:16] == VP_BASE) &&
                           (req_i.addr[15:2] == VP_STDOUT_OFS[15:2]);
    assign vp_status_hit = HAS_VP && (req_i.addr[31:16] == VP_BASE) &&
                           (req_i.addr[15:2] == VP_STATUS_OFS[15:2]);
    assign vp_hit        = vp_stdout_hit | vp_status_hit;

    // ----------------------------------------
    // Downstream accesses
    // ----------------------------------------

    // RAM port, reads and writes share one enable
    assign ram_en_o    = req_ok & ram_hit;
    assign ram_we_o    = req_ok & ram_hit & req_i.we;
    assign ram_be_o    = req_i.be;
    assign ram_addr_o  = req_i.addr[RAM_ADDR_WIDTH-1:2];
    assign ram_wdata_o = req_i.wdata;

    // Peripheral write, a read needs no strobe since status is always presented
    assign vp_wr_o.stb   = req_ok & vp_hit & req_i.we;
    assign vp_wr_o.sel   = vp_status_hit;
    assign vp_wr_o.be    = req_i.be;
    assign vp_wr_o.wdata = req_i.wdata;

    assign par_err_o = par_err;

    // ----------------------------------------
    // Response stage
    // ----------------------------------------

    logic rvalid_q;
    logic err_q;
    logic rd_ram_q;
    logic rd_vp_q;

    // Every request is granted, the response follows one cycle later
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
            rd_ram_q <= 1'b0;
            rd_vp_q  <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;
            // Parity fault or an unmapped address
            err_q    <= req_i.req & (par_err | ~(ram_hit | vp_hit));
            // Read source for the response cycle
            rd_ram_q <= req_ok & ram_hit & ~req_i.we;
            rd_vp_q  <= req_ok & vp_status_hit & ~req_i.we;
        end
    end

    assign rsp_o.gnt    = req_i.req;
    assign rsp_o.rvalid = rvalid_q;
    assign rsp_o.err    = err_q;

    // Stdout reads, writes and errors return zero
    always_comb begin
        if (rd_ram_q) begin
            rsp_o.rdata = ram_rdata_i;
        end else if (rd_vp_q) begin
            rsp_o.rdata = vp_rdata_i;
        end else begin
            rsp_o.rdata = '0;
        end
    end

endmodule : obi_resp_port

//--- hw/obi_mem_sys.sv
// Memory and peripheral subsystem top with instruction and data OBI ports

`timescale 1ns/100ps

module obi_mem_sys import obi_sys_pkg::*; #(
    parameter int unsigned RAM_ADDR_WIDTH = 12
) (
    input  logic        clk_i,
    input  logic        rst_i,

    // Instruction fetch OBI, we, be and wdata are ignored
    input  obi_req_t    instr_req_i,
    output obi_rsp_t    instr_rsp_o,

    // Data OBI
    input  obi_req_t    data_req_i,
    output obi_rsp_t    data_rsp_o,

    // Virtual peripheral outputs
    output logic [7:0]  stdout_char_o,
    output logic        stdout_valid_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_code_o,

    // Parity fault on either port
    output logic        alert_major_o
);

    // ----------------------------------------
    // Instruction port tie-offs
    // ----------------------------------------

    obi_req_t instr_req;

    // Fetches are full-word reads
    always_comb begin
        instr_req        = instr_req_i;
        instr_req.we     = 1'b0;
        instr_req.be     = 4'hf;
        instr_req.wdata  = '0;
    end

    // ----------------------------------------
    // Port to RAM wiring
    // ----------------------------------------

    logic                      instr_ram_en;
    logic [RAM_ADDR_WIDTH-3:0] instr_ram_addr;
    logic [31:0]               instr_ram_rdata;
    logic                      instr_par_err;

    logic                      data_ram_en;
    logic                      data_ram_we;
    logic [3:0]                data_ram_be;
    logic [RAM_ADDR_WIDTH-3:0] data_ram_addr;
    logic [31:0]               data_ram_wdata;
    logic [31:0]               data_ram_rdata;
    logic                      data_par_err;

    vp_wr_t                    vp_wr;
    logic [31:0]               vp_rdata;

    // Fetch side, no peripherals and the RAM write outputs stay open
    obi_resp_port #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .HAS_VP         (1'b0)
    ) instr_port_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (instr_req),
        .rsp_o       (instr_rsp_o),
        .ram_en_o    (instr_ram_en),
        .ram_we_o    (),
        .ram_be_o    (),
        .ram_addr_o  (instr_ram_addr),
        .ram_wdata_o (),
        .ram_rdata_i (instr_ram_rdata),
        .vp_wr_o     (),
        .vp_rdata_i  ('0),
        .par_err_o   (instr_par_err)
    );

    obi_resp_port #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .HAS_VP         (1'b1)
    ) data_port_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (data_req_i),
        .rsp_o       (data_rsp_o),
        .ram_en_o    (data_ram_en),
        .ram_we_o    (data_ram_we),
        .ram_be_o    (data_ram_be),
        .ram_addr_o  (data_ram_addr),
        .ram_wdata_o (data_ram_wdata),
        .ram_rdata_i (data_ram_rdata),
        .vp_wr_o     (vp_wr),
        .vp_rdata_i  (vp_rdata),
        .par_err_o   (data_par_err)
    );

    // Port a serves fetches, port b the data side
    dp_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) ram_i (
        .clk_i     (clk_i),
        .a_en_i    (instr_ram_en),
        .a_addr_i  (instr_ram_addr),
        .a_rdata_o (instr_ram_rdata),
        .b_en_i    (data_ram_en),
        .b_we_i    (data_ram_we),
        .b_be_i    (data_ram_be),
        .b_addr_i  (data_ram_addr),
        .b_wdata_i (data_ram_wdata),
        .b_rdata_o (data_ram_rdata)
    );

    vp_periph vp_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .vp_wr_i        (vp_wr),
        .vp_rdata_o     (vp_rdata),
        .stdout_char_o  (stdout_char_o),
        .stdout_valid_o (stdout_valid_o),
        .exit_valid_o   (exit_valid_o),
        .exit_code_o    (exit_code_o)
    );

    // Either port can raise the alert
    assign alert_major_o = instr_par_err | data_par_err;

endmodule : obi_mem_sys

//--- testbench/obi_mem_sys_chk.sv
// OBI timing assertions for one response port, bound into every obi_resp_port

`timescale 1ns/100ps

module obi_mem_sys_chk import obi_sys_pkg::*; (
    input logic     clk_i,
    input logic     rst_i,
    input obi_req_t req_i,
    input obi_rsp_t rsp_i
);

    // Synchronous reset clears the response stage
    reset_clears_rvalid: assert property (@(posedge clk_i) rst_i |=> !rsp_i.rvalid)
        else $error("rvalid high in the cycle after reset");

    // Every accepted request is answered in the next cycle
    rvalid_after_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        (req_i.req && rsp_i.gnt) |=> rsp_i.rvalid)
        else $error("rvalid missing one cycle after a grant");

    // No response without a grant one cycle earlier
    rvalid_needs_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        !(req_i.req && rsp_i.gnt) |=> !rsp_i.rvalid)
        else $error("rvalid without a grant in the previous cycle");

    // Grant only for a pending request
    gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_i.gnt |-> req_i.req)
        else $error("gnt without req");

endmodule : obi_mem_sys_chk

bind obi_resp_port obi_mem_sys_chk port_chk_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (req_i),
    .rsp_i (rsp_o)
);

//--- testbench/tb_obi_mem_sys.sv
// Testbench for obi_mem_sys with stimulus table, RAM reference model and compare tasks

`timescale 1ns/100ps

module tb_obi_mem_sys import obi_sys_pkg::*; ();

    localparam int unsigned RAM_AW     = 10;
    localparam int unsigned WAIT_LIMIT = 16;
    localparam logic        P_INSTR    = 1'b0;
    localparam logic        P_DATA     = 1'b1;

    // Expected outcome of one request
    typedef enum logic [1:0] {K_RAM, K_ERR, K_STDOUT, K_STATUS} kind_e;

    typedef struct packed {
        logic        port;
        logic        par_bad;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
        kind_e       kind;
    } stim_t;

    logic        clk_i;
    logic        rst_i;
    obi_req_t    instr_req;
    obi_rsp_t    instr_rsp;
    obi_req_t    data_req;
    obi_rsp_t    data_rsp;
    logic [7:0]  stdout_char;
    logic        stdout_valid;
    logic        exit_valid;
    logic [31:0] exit_code;
    logic        alert_major;

    // Reference state, RAM words keyed by word index
    logic [31:0] ram_model [int unsigned];
    logic        exit_model;
    logic [31:0] status_model;
    logic [31:0] lcg_state;
    stim_t       stim_q [$];

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    obi_mem_sys #(
        .RAM_ADDR_WIDTH (RAM_AW)
    ) obi_mem_sys_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_req_i    (instr_req),
        .instr_rsp_o    (instr_rsp),
        .data_req_i     (data_req),
        .data_rsp_o     (data_rsp),
        .stdout_char_o  (stdout_char),
        .stdout_valid_o (stdout_valid),
        .exit_valid_o   (exit_valid),
        .exit_code_o    (exit_code),
        .alert_major_o  (alert_major)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Valid request, correct parity is the inverse of req
    function automatic obi_req_t make_req(input logic par_bad, input logic we,
                                          input logic [3:0] be, input logic [31:0] addr,
                                          input logic [31:0] wdata);
        obi_req_t r;
        r.req    = 1'b1;
        r.reqpar = par_bad;
        r.we     = we;
        r.be     = be;
        r.addr   = addr;
        r.wdata  = wdata;
        return r;
    endfunction

    function automatic obi_req_t idle_req();
        obi_req_t r;
        r        = '0;
        r.reqpar = 1'b1;
        return r;
    endfunction

    // Byte-lane merge of a write into the old word
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic void add_row(input logic port, input logic par_bad, input logic we,
                                    input logic [3:0] be, input logic [31:0] addr,
                                    input logic [31:0] wdata, input kind_e kind);
        stim_t row;
        row.port    = port;
        row.par_bad = par_bad;
        row.we      = we;
        row.be      = be;
        row.addr    = addr;
        row.wdata   = wdata;
        row.kind    = kind;
        stim_q.push_back(row);
    endfunction

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic model_read(input int unsigned word, output logic [31:0] data);
        if (!ram_model.exists(word)) begin
            fail_run($sformatf("Reference model holds no data for word %0d", word));
        end else begin
            data = ram_model[word];
        end
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    task automatic check_rsp(input string port, input obi_rsp_t act, input obi_rsp_t exp,
                             input bit cmp_data);
        if (act.gnt !== exp.gnt || act.rvalid !== exp.rvalid || act.err !== exp.err ||
            (cmp_data && act.rdata !== exp.rdata)) begin
            fail_run($sformatf("error at %0t: %s rsp gnt=%b rvalid=%b err=%b rdata=%h, %s",
                               $time, port, act.gnt, act.rvalid, act.err, act.rdata,
                               $sformatf("expected gnt=%b rvalid=%b err=%b rdata=%h",
                                         exp.gnt, exp.rvalid, exp.err, exp.rdata)));
        end
    endtask

    task automatic check_stdout(input logic act_valid, input logic [7:0] act_char,
                                input logic exp_valid, input logic [7:0] exp_char);
        if (act_valid !== exp_valid || (exp_valid && act_char !== exp_char)) begin
            fail_run($sformatf("error at %0t: stdout valid=%b char=%h, expected %b %h",
                               $time, act_valid, act_char, exp_valid, exp_char));
        end
    endtask

    task automatic check_exit(input logic act_valid, input logic [31:0] act_code,
                              input logic exp_valid, input logic [31:0] exp_code);
        if (act_valid !== exp_valid || (exp_valid && act_code !== exp_code)) begin
            fail_run($sformatf("error at %0t: exit valid=%b code=%h, expected %b %h",
                               $time, act_valid, act_code, exp_valid, exp_code));
        end
    endtask

    task automatic check_alert(input logic act, input logic exp);
        if (act !== exp) begin
            fail_run($sformatf("error at %0t: alert_major=%b, expected %b", $time, act, exp));
        end
    endtask

    // Returns at the negedge of the cycle in which every wanted port is granted
    task automatic wait_grant(input bit want_i, input bit want_d);
        int unsigned cycles;
        cycles = 0;
        @(negedge clk_i);
        while ((want_i && instr_rsp.gnt !== 1'b1) || (want_d && data_rsp.gnt !== 1'b1)) begin
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                fail_run("Timed out waiting for a grant from the DUT");
            end
            @(negedge clk_i);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    // One request alone, response checked in the cycle after the grant
    task automatic apply_row(input stim_t row);
        obi_rsp_t    exp;
        obi_rsp_t    idle_exp;
        logic [31:0] old_word;
        logic [31:0] rd_word;
        bit          is_write;
        bit          cmp_data;
        bit          pulse;
        int unsigned word;
        // Fetches never write whatever we says
        is_write   = (row.port == P_DATA) && row.we;
        word       = row.addr >> 2;
        cmp_data   = 1'b0;
        pulse      = 1'b0;
        exp        = '0;
        idle_exp   = '0;
        exp.rvalid = 1'b1;
        exp.err    = (row.kind == K_ERR);
        @(posedge clk_i);
        #1;
        if (row.port == P_DATA) begin
            data_req = make_req(row.par_bad, row.we, row.be, row.addr, row.wdata);
        end else begin
            instr_req = make_req(row.par_bad, row.we, row.be, row.addr, row.wdata);
        end
        wait_grant(row.port == P_INSTR, row.port == P_DATA);
        // Grant cycle, alert follows the request directly
        check_alert(alert_major, row.par_bad);
        check_stdout(stdout_valid, stdout_char, 1'b0, 8'h00);
        check_exit(exit_valid, exit_code, exit_model, status_model);
        case (row.kind)
            K_RAM: begin
                if (is_write) begin
                    old_word = ram_model.exists(word) ? ram_model[word] : 32'hx;
                    ram_model[word] = merge_lanes(old_word, row.wdata, row.be);
                end else begin
                    model_read(word, rd_word);
                    exp.rdata = rd_word;
                    cmp_data  = 1'b1;
                end
            end
            K_STDOUT: begin
                // A stdout read returns zero
                pulse    = is_write;
                cmp_data = !is_write;
            end
            K_STATUS: begin
                if (is_write) begin
                    exit_model   = 1'b1;
                    status_model = row.wdata;
                end else begin
                    exp.rdata = status_model;
                    cmp_data  = 1'b1;
                end
            end
            default: begin
            end
        endcase
        @(posedge clk_i);
        #1;
        instr_req = idle_req();
        data_req  = idle_req();
        @(negedge clk_i);
        // Read data only means something on the port that answered
        check_rsp("data", data_rsp, (row.port == P_DATA) ? exp : idle_exp,
                  cmp_data && (row.port == P_DATA));
        check_rsp("instr", instr_rsp, (row.port == P_INSTR) ? exp : idle_exp,
                  cmp_data && (row.port == P_INSTR));
        check_alert(alert_major, 1'b0);
        check_stdout(stdout_valid, stdout_char, pulse, row.wdata[7:0]);
        check_exit(exit_valid, exit_code, exit_model, status_model);
    endtask

    // Requests on both ports in every cycle, responses checked in order
    task automatic stream_pass(input int unsigned base, input int unsigned n,
                               input bit do_write);
        logic [31:0] exp_d_q [$];
        logic [31:0] exp_i_q [$];
        obi_rsp_t    exp;
        logic [31:0] data;
        logic [31:0] rd_word;
        int unsigned d_word;
        int unsigned i_word;
        for (int unsigned i = 0; i <= n; i++) begin
            @(posedge clk_i);
            #1;
            if (i < n) begin
                d_word = base + i;
                // Fetch hits the word under write, or walks downward on reads
                i_word    = do_write ? d_word : base + n - 1 - i;
                data      = lcg_next();
                data_req  = make_req(1'b0, do_write, 4'hf, d_word << 2, data);
                instr_req = make_req(1'b0, 1'b0, 4'hf, i_word << 2, 32'h0);
                wait_grant(1'b1, 1'b1);
            end else begin
                instr_req = idle_req();
                data_req  = idle_req();
                @(negedge clk_i);
            end
            check_alert(alert_major, 1'b0);
            if (i > 0) begin
                exp        = '0;
                exp.gnt    = (i < n);
                exp.rvalid = 1'b1;
                exp.rdata  = exp_d_q.pop_front();
                check_rsp("data", data_rsp, exp, !do_write);
                exp.rdata  = exp_i_q.pop_front();
                check_rsp("instr", instr_rsp, exp, 1'b1);
            end
            if (i < n) begin
                // Same-cycle fetch of a word under write sees the old word
                model_read(i_word, rd_word);
                exp_i_q.push_back(rd_word);
                if (do_write) begin
                    ram_model[d_word] = data;
                    exp_d_q.push_back(32'h0);
                end else begin
                    model_read(d_word, rd_word);
                    exp_d_q.push_back(rd_word);
                end
            end
        end
    endtask

    function automatic void build_table();
        // Mixed byte-lane writes, then reads on both ports
        add_row(P_DATA,  1'b0, 1'b1, 4'b0011, 32'h0000_0010, 32'ha5a5_1234, K_RAM);
        add_row(P_DATA,  1'b0, 1'b1, 4'b1100, 32'h0000_0014, 32'hdead_beef, K_RAM);
        add_row(P_DATA,  1'b0, 1'b1, 4'b0101, 32'h0000_0018, 32'h1122_3344, K_RAM);
        add_row(P_DATA,  1'b0, 1'b1, 4'b1000, 32'h0000_001c, 32'h9900_0000, K_RAM);
        add_row(P_DATA,  1'b0, 1'b1, 4'b1111, 32'h0000_0200, 32'hcafe_f00d, K_RAM);
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h0000_0010, 32'h0,         K_RAM);
        add_row(P_INSTR, 1'b0, 1'b0, 4'b1111, 32'h0000_0014, 32'h0,         K_RAM);
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h0000_0018, 32'h0,         K_RAM);
        add_row(P_INSTR, 1'b0, 1'b0, 4'b1111, 32'h0000_001c, 32'h0,         K_RAM);
        add_row(P_INSTR, 1'b0, 1'b0, 4'b1111, 32'h0000_0200, 32'h0,         K_RAM);
        // A fetch with we set still reads and leaves the word alone
        add_row(P_INSTR, 1'b0, 1'b1, 4'b0000, 32'h0000_0018, 32'h0bad_f00d, K_RAM);
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h0000_0018, 32'h0,         K_RAM);
        // Stdout writes and a stdout read
        add_row(P_DATA,  1'b0, 1'b1, 4'b1111, 32'h8000_0000, 32'h0000_0048, K_STDOUT);
        add_row(P_DATA,  1'b0, 1'b1, 4'b0001, 32'h8000_0000, 32'h1234_5669, K_STDOUT);
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h8000_0000, 32'h0,         K_STDOUT);
        // Exit status, readback, then more traffic
        add_row(P_DATA,  1'b0, 1'b1, 4'b1111, 32'h8000_0004, 32'h0000_002a, K_STATUS);
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h8000_0004, 32'h0,         K_STATUS);
        add_row(P_INSTR, 1'b0, 1'b0, 4'b1111, 32'h0000_0020, 32'h0,         K_RAM);
        // Unmapped addresses, 0x0001_0010 aliases word 4 if the upper bits were ignored
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h0000_0400, 32'h0,         K_ERR);
        add_row(P_DATA,  1'b0, 1'b1, 4'b1111, 32'h0001_0010, 32'h5555_aaaa, K_ERR);
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h0000_0010, 32'h0,         K_RAM);
        add_row(P_INSTR, 1'b0, 1'b0, 4'b1111, 32'h8000_0004, 32'h0,         K_ERR);
        add_row(P_INSTR, 1'b0, 1'b0, 4'b1111, 32'h8000_0000, 32'h0,         K_ERR);
        // Bad parity, nothing may change
        add_row(P_DATA,  1'b1, 1'b1, 4'b1111, 32'h0000_0010, 32'hffff_ffff, K_ERR);
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h0000_0010, 32'h0,         K_RAM);
        add_row(P_INSTR, 1'b1, 1'b0, 4'b1111, 32'h0000_0014, 32'h0,         K_ERR);
        add_row(P_DATA,  1'b1, 1'b1, 4'b1111, 32'h8000_0004, 32'h0000_0055, K_ERR);
        add_row(P_DATA,  1'b0, 1'b0, 4'b1111, 32'h8000_0004, 32'h0,         K_STATUS);
    endfunction

    initial begin
        stim_t    row;
        obi_rsp_t idle_rsp;
        $timeformat(-9, 1, " ns", 10);
        lcg_state    = 32'h14ed;
        exit_model   = 1'b0;
        status_model = 32'h0;
        idle_rsp     = '0;
        rst_i        = 1'b1;
        instr_req    = idle_req();
        data_req     = idle_req();
        build_table();
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        // Quiet outputs after reset
        check_rsp("instr", instr_rsp, idle_rsp, 1'b0);
        check_rsp("data", data_rsp, idle_rsp, 1'b0);
        check_stdout(stdout_valid, stdout_char, 1'b0, 8'h00);
        check_exit(exit_valid, exit_code, 1'b0, 32'h0);
        check_alert(alert_major, 1'b0);
        // Random fill of the lower 64 words
        for (int unsigned w = 0; w < 64; w++) begin
            row       = '0;
            row.port  = P_DATA;
            row.we    = 1'b1;
            row.be    = 4'hf;
            row.addr  = w << 2;
            row.wdata = lcg_next();
            row.kind  = K_RAM;
            apply_row(row);
        end
        stream_pass(0, 32, 1'b1);
        stream_pass(0, 32, 1'b0);
        foreach (stim_q[k]) begin
            apply_row(stim_q[k]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule : tb_obi_mem_sys

//--- vlog.f
hw/obi_sys_pkg.sv
hw/dp_ram.sv
hw/vp_periph.sv
hw/obi_resp_port.sv
hw/obi_mem_sys.sv
testbench/obi_mem_sys_chk.sv
testbench/tb_obi_mem_sys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the obi_mem_sys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_obi_mem_sys -Mdir obj_dir -f vlog.f

status=0
./obj_dir/Vtb_obi_mem_sys > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a clean result"
    exit 1
fi
